//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := l2_cache_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb import l2_pkg::*; ();
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MEM_WORDS      = 1024;
    localparam int RESP_DELAY     = 3;

    logic        clk;
    logic        arst_n;
    logic        i_req;
    logic [31:0] i_addr;
    logic        d_req;
    logic        d_wr;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic [3:0]  d_wstrb;
    logic        i_addr_ok;
    logic        d_addr_ok;
    logic        i_data_ok;
    logic        d_data_ok;
    l1_line_t    i_rdata;
    l1_line_t    d_rdata;
    logic        mem_rd_req;
    logic [31:0] mem_rd_addr;
    logic        mem_rd_valid;
    line_t       mem_rd_line;
    logic        mem_wr_req;
    logic [31:0] mem_wr_addr;
    line_t       mem_wr_line;
    logic        mem_wr_done;

    int          cycle = 0;
    int          errors = 0;
    int          rd_count = 0;
    logic [31:0] mem_words [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] wb_addr_q [$];
    line_t       wb_line_q [$];
    line_t       rd_buf;

    tb_clk_gen u_clk (.clk(clk), .arst_n(arst_n));

    l2_cache dut (
        .clk(clk), .arst_n(arst_n),
        .i_req(i_req), .i_addr(i_addr),
        .d_req(d_req), .d_wr(d_wr), .d_addr(d_addr), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
        .i_addr_ok(i_addr_ok), .d_addr_ok(d_addr_ok),
        .i_data_ok(i_data_ok), .d_data_ok(d_data_ok),
        .i_rdata(i_rdata), .d_rdata(d_rdata),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr),
        .mem_rd_valid(mem_rd_valid), .mem_rd_line(mem_rd_line),
        .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr),
        .mem_wr_line(mem_wr_line), .mem_wr_done(mem_wr_done)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the cache did not answer within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic line_t mem_line(input logic [5:0] ln);
        line_t l;
        for (int w = 0; w < 16; w++) begin
            l[w * 32 +: 32] = mem_words[{ln, 4'(w)}];
        end
        return l;
    endfunction

    function automatic line_t shadow_line(input logic [5:0] ln);
        line_t l;
        for (int w = 0; w < 16; w++) begin
            l[w * 32 +: 32] = shadow[{ln, 4'(w)}];
        end
        return l;
    endfunction

    function automatic l1_line_t shadow_l1(input logic [31:0] addr);
        l1_line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k * 32 +: 32] = shadow[{addr[11:4], 2'(k)}];
        end
        return l;
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] wstrb);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                shadow[addr[11:2]][b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
    endtask

    // Memory model serves one transaction at a time after RESP_DELAY cycles
    initial begin
        mem_rd_valid = 1'b0;
        mem_rd_line  = '0;
        mem_wr_done  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = (32'(i) << 2) ^ 32'hA5A5_0000;
        end
        forever begin
            @(negedge clk);
            if (arst_n && mem_wr_req) begin
                wb_addr_q.push_back(mem_wr_addr);
                wb_line_q.push_back(mem_wr_line);
                for (int w = 0; w < 16; w++) begin
                    mem_words[{mem_wr_addr[11:6], 4'(w)}] = mem_wr_line[w * 32 +: 32];
                end
                repeat (RESP_DELAY) @(posedge clk);
                #1 mem_wr_done = 1'b1;
                @(posedge clk);
                #1 mem_wr_done = 1'b0;
            end else if (arst_n && mem_rd_req) begin
                rd_count++;
                rd_buf = mem_line(mem_rd_addr[11:6]);
                repeat (RESP_DELAY) @(posedge clk);
                #1;
                mem_rd_valid = 1'b1;
                mem_rd_line  = rd_buf;
                @(posedge clk);
                #1 mem_rd_valid = 1'b0;
            end
        end
    end

    task automatic check_eq(input logic [511:0] actual, input logic [511:0] expected,
                            input string what);
        if (actual !== expected) begin
            errors++;
            $display("** Error at time %0t: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // One L1 transfer; ok_cycle is when addr_ok showed, lat counts cycles to data_ok
    task automatic l1_access(input bit use_d, input bit wr, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb,
                             output l1_line_t rd, output int ok_cycle, output int lat);
        bit seen;
        @(posedge clk);
        #1;
        if (use_d) begin
            d_req   = 1'b1;
            d_wr    = wr;
            d_addr  = addr;
            d_wdata = wdata;
            d_wstrb = wstrb;
        end else begin
            i_req  = 1'b1;
            i_addr = addr;
        end
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = use_d ? d_addr_ok : i_addr_ok;
        end
        ok_cycle = cycle;
        @(posedge clk);
        #1;
        if (use_d) begin
            d_req = 1'b0;
        end else begin
            i_req = 1'b0;
        end
        lat  = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            lat++;
            seen = use_d ? d_data_ok : i_data_ok;
        end
        rd = use_d ? d_rdata : i_rdata;
    endtask

    task automatic idle_stays_quiet();
        for (int n = 0; n < 10; n++) begin
            @(negedge clk);
            check_eq(512'({i_addr_ok, d_addr_ok, i_data_ok, d_data_ok, mem_rd_req, mem_wr_req}),
                     512'(0), "strobe raised with no request");
        end
    endtask

    // Set 0 starts empty, so ways fill 0..3 and the tree then points at way 0
    task automatic evict_dirty_line();
        l1_line_t    rd;
        int          okc;
        int          lat;
        int          wb_before;
        int          rd_before;
        logic [31:0] a_addr;
        logic [31:0] addr;
        a_addr    = 32'h0000_0108;
        wb_before = wb_addr_q.size();
        shadow_write(a_addr, 32'h1234_5678, 4'hF);
        l1_access(1'b1, 1'b1, a_addr, 32'h1234_5678, 4'hF, rd, okc, lat);
        check_eq(512'(rd), 512'(shadow_l1(a_addr)), "write to line A");
        for (int t = 2; t <= 5; t++) begin
            addr = {20'd0, 4'(t), 2'b00, 6'h04};
            l1_access(1'b0, 1'b0, addr, 32'h0, 4'h0, rd, okc, lat);
            check_eq(512'(rd), 512'(shadow_l1(addr)), "read of another tag in set 0");
        end
        check_eq(512'(wb_addr_q.size() - wb_before), 512'(1), "writeback count");
        check_eq(512'(wb_addr_q[$]), 512'({a_addr[31:6], 6'd0}), "writeback address");
        check_eq(wb_line_q[$], shadow_line(a_addr[11:6]), "writeback line");
        rd_before = rd_count;
        l1_access(1'b1, 1'b0, a_addr, 32'h0, 4'h0, rd, okc, lat);
        check_eq(512'(rd_count - rd_before), 512'(1), "refetch of line A");
        check_eq(512'(rd), 512'(shadow_l1(a_addr)), "reread of line A");
        check_eq(512'(wb_addr_q.size() - wb_before), 512'(1), "no extra writeback");
    endtask

    task automatic read_i_line_twice();
        l1_line_t    rd;
        int          okc;
        int          lat;
        int          rd_before;
        logic [31:0] addr;
        addr = 32'h0000_0054;
        l1_access(1'b0, 1'b0, addr, 32'h0, 4'h0, rd, okc, lat);
        check_eq(512'(rd), 512'(shadow_l1(addr)), "I read miss data");
        check_eq(512'(lat > 1), 512'(1'b1), "I read miss latency");
        rd_before = rd_count;
        l1_access(1'b0, 1'b0, addr, 32'h0, 4'h0, rd, okc, lat);
        check_eq(512'(rd), 512'(shadow_l1(addr)), "I read hit data");
        check_eq(512'(lat), 512'(1), "hit data_ok one cycle after addr_ok");
        check_eq(512'(rd_count - rd_before), 512'(0), "no memory read on hit");
    endtask

    task automatic write_partial_word();
        l1_line_t    rd;
        int          okc;
        int          lat;
        logic [31:0] addr;
        logic [31:0] old_word;
        logic [31:0] exp_word;
        addr     = 32'h0000_0098;
        old_word = shadow[addr[11:2]];
        // Strobes 0101 replace bytes 0 and 2 only
        exp_word = (old_word & 32'hFF00_FF00) | (32'hDEAD_BEEF & 32'h00FF_00FF);
        shadow_write(addr, 32'hDEAD_BEEF, 4'b0101);
        l1_access(1'b1, 1'b1, addr, 32'hDEAD_BEEF, 4'b0101, rd, okc, lat);
        check_eq(512'(rd), 512'(shadow_l1(addr)), "partial write response");
        l1_access(1'b1, 1'b0, addr, 32'h0, 4'h0, rd, okc, lat);
        check_eq(512'(rd), 512'(shadow_l1(addr)), "read after partial write");
        check_eq(512'(rd[int'(addr[3:2]) * 32 +: 32]), 512'(exp_word), "merged word");
    endtask

    task automatic race_both_sides();
        l1_line_t    d_rd;
        l1_line_t    i_rd;
        int          d_okc;
        int          i_okc;
        int          d_lat;
        int          i_lat;
        logic [31:0] dside_addr;
        logic [31:0] iside_addr;
        dside_addr = 32'h0000_00C4;
        iside_addr = 32'h0000_01C8;
        fork
            l1_access(1'b1, 1'b0, dside_addr, 32'h0, 4'h0, d_rd, d_okc, d_lat);
            l1_access(1'b0, 1'b0, iside_addr, 32'h0, 4'h0, i_rd, i_okc, i_lat);
        join
        check_eq(512'(d_okc < i_okc), 512'(1'b1), "data side accepted first");
        check_eq(512'(d_rd), 512'(shadow_l1(dside_addr)), "D data in same-cycle test");
        check_eq(512'(i_rd), 512'(shadow_l1(iside_addr)), "I data in same-cycle test");
    endtask

    // Five lines share set 0, so dirty evictions happen often
    task automatic run_random_mix();
        logic [5:0]  pool [8];
        logic [5:0]  ln;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        bit          wr;
        bit          use_d;
        l1_line_t    rd;
        int          okc;
        int          lat;
        pool = '{6'd0, 6'd4, 6'd8, 6'd12, 6'd16, 6'd1, 6'd5, 6'd2};
        for (int n = 0; n < 200; n++) begin
            ln    = pool[3'($urandom_range(7, 0))];
            addr  = {20'd0, ln, 4'($urandom_range(15, 0)), 2'b00};
            wr    = 1'($urandom_range(1, 0));
            use_d = wr | 1'($urandom_range(1, 0));
            wdata = $urandom;
            wstrb = 4'($urandom_range(15, 1));
            if (wr) begin
                shadow_write(addr, wdata, wstrb);
            end
            l1_access(use_d, wr, addr, wdata, wstrb, rd, okc, lat);
            check_eq(512'(rd), 512'(shadow_l1(addr)), "random access data");
        end
    endtask

    initial begin
        i_req   = 1'b0;
        i_addr  = '0;
        d_req   = 1'b0;
        d_wr    = 1'b0;
        d_addr  = '0;
        d_wdata = '0;
        d_wstrb = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = (32'(i) << 2) ^ 32'hA5A5_0000;
        end
        void'($urandom(32'h51d1));
        wait (arst_n === 1'b1);
        idle_stays_quiet();
        evict_dirty_line();
        read_i_line_twice();
        write_partial_word();
        race_both_sides();
        run_random_mix();
        idle_stays_quiet();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "mismatches were found");
        end
    end

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release just after an edge, like the other stimulus
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

//--- hw/l2_cache.sv
`timescale 1ns/1ps

module l2_cache import l2_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        i_req,
    input  logic [31:0] i_addr,
    input  logic        d_req,
    input  logic        d_wr,
    input  logic [31:0] d_addr,
    input  logic [31:0] d_wdata,
    input  logic [3:0]  d_wstrb,
    output logic        i_addr_ok,
    output logic        d_addr_ok,
    output logic        i_data_ok,
    output logic        d_data_ok,
    output l1_line_t    i_rdata,
    output l1_line_t    d_rdata,
    output logic        mem_rd_req,
    output logic [31:0] mem_rd_addr,
    input  logic        mem_rd_valid,
    input  line_t       mem_rd_line,
    output logic        mem_wr_req,
    output logic [31:0] mem_wr_addr,
    output line_t       mem_wr_line,
    input  logic        mem_wr_done
);
    logic                load;
    logic                pending;
    req_src_t            buf_src;
    logic [31:0]         buf_addr;
    logic [31:0]         buf_wdata;
    logic [3:0]          buf_wstrb;
    logic [INDEX_W-1:0]  rd_index;
    logic [INDEX_W-1:0]  wr_index;
    logic [NUM_WAYS-1:0] tag_we;
    logic [NUM_WAYS-1:0] line_we;
    tag_entry_t          tag_wdata;
    line_t               line_wdata;
    tag_entry_t          tag_rd [NUM_WAYS];
    line_t               line_rd [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_valid;
    logic                touch;
    logic [1:0]          touch_way;
    logic [1:0]          victim;
    l1_line_t            rdata;

    assign i_rdata = rdata;
    assign d_rdata = rdata;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_valid
        assign way_valid[w] = tag_rd[w].valid;
    end

    l2_req_buffer u_buf (
        .clk(clk), .arst_n(arst_n), .load(load),
        .i_req(i_req), .i_addr(i_addr),
        .d_req(d_req), .d_wr(d_wr), .d_addr(d_addr), .d_wdata(d_wdata), .d_wstrb(d_wstrb),
        .i_addr_ok(i_addr_ok), .d_addr_ok(d_addr_ok),
        .buf_src(buf_src), .buf_addr(buf_addr), .buf_wdata(buf_wdata),
        .buf_wstrb(buf_wstrb), .pending(pending)
    );

    l2_set_ram #(.entry_t(tag_entry_t)) u_tags (
        .clk(clk), .arst_n(arst_n), .rd_index(rd_index), .wr_index(wr_index),
        .wr_en(tag_we), .wr_data(tag_wdata), .rd_ways(tag_rd)
    );

    l2_set_ram #(.entry_t(line_t)) u_lines (
        .clk(clk), .arst_n(arst_n), .rd_index(rd_index), .wr_index(wr_index),
        .wr_en(line_we), .wr_data(line_wdata), .rd_ways(line_rd)
    );

    l2_plru u_plru (
        .clk(clk), .arst_n(arst_n), .index(rd_index), .touch(touch),
        .touch_way(touch_way), .valid(way_valid), .victim(victim)
    );

    l2_ctrl u_ctrl (
        .clk(clk), .arst_n(arst_n), .pending(pending),
        .buf_src(buf_src), .buf_addr(buf_addr), .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb),
        .tags(tag_rd), .lines(line_rd), .victim(victim),
        .mem_rd_valid(mem_rd_valid), .mem_rd_line(mem_rd_line), .mem_wr_done(mem_wr_done),
        .load(load), .rd_index(rd_index), .wr_index(wr_index),
        .tag_we(tag_we), .line_we(line_we), .tag_wdata(tag_wdata), .line_wdata(line_wdata),
        .touch(touch), .touch_way(touch_way),
        .i_data_ok(i_data_ok), .d_data_ok(d_data_ok), .rdata(rdata),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .mem_rd_addr(mem_rd_addr), .mem_wr_addr(mem_wr_addr), .mem_wr_line(mem_wr_line)
    );

endmodule

//--- hw/l2_ctrl.sv
`timescale 1ns/1ps

module l2_ctrl import l2_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pending,
    input  req_src_t            buf_src,
    input  logic [31:0]         buf_addr,
    input  logic [31:0]         buf_wdata,
    input  logic [3:0]          buf_wstrb,
    input  tag_entry_t          tags [NUM_WAYS],
    input  line_t               lines [NUM_WAYS],
    input  logic [1:0]          victim,
    input  logic                mem_rd_valid,
    input  line_t               mem_rd_line,
    input  logic                mem_wr_done,
    output logic                load,
    output logic [INDEX_W-1:0]  rd_index,
    output logic [INDEX_W-1:0]  wr_index,
    output logic [NUM_WAYS-1:0] tag_we,
    output logic [NUM_WAYS-1:0] line_we,
    output tag_entry_t          tag_wdata,
    output line_t               line_wdata,
    output logic                touch,
    output logic [1:0]          touch_way,
    output logic                i_data_ok,
    output logic                d_data_ok,
    output l1_line_t            rdata,
    output logic                mem_rd_req,
    output logic                mem_wr_req,
    output logic [31:0]         mem_rd_addr,
    output logic [31:0]         mem_wr_addr,
    output line_t               mem_wr_line
);
    typedef enum logic [2:0] {
        S_IDLE, S_LOOKUP, S_WB_REQ, S_WB_WAIT, S_RF_REQ, S_RF_WAIT, S_RESPOND
    } state_t;

    state_t              state_q;
    state_t              state_d;
    logic [1:0]          way_q;
    logic                wb_open_q;
    logic [TAG_W-1:0]    buf_tag;
    logic [INDEX_W-1:0]  buf_index;
    logic [OFFSET_W-1:0] buf_offset;
    logic                is_write;
    logic                hit;
    logic [1:0]          hit_way;
    line_t               way_line;
    line_t               base_line;

    function automatic line_t merge_word(line_t base, logic [OFFSET_W-1:0] off,
                                         logic [31:0] wdata, logic [3:0] wstrb);
        line_t res;
        res = base;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                res[int'(off) * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        return res;
    endfunction

    assign buf_tag    = buf_addr[31 -: TAG_W];
    assign buf_index  = buf_addr[OFFSET_W + 2 +: INDEX_W];
    assign buf_offset = buf_addr[2 +: OFFSET_W];
    assign is_write   = (buf_src == SRC_DWRITE);
    assign rd_index   = buf_index;
    assign wr_index   = buf_index;
    assign load       = (state_q == S_IDLE) & pending;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tags[w].valid && tags[w].tag == buf_tag) begin
                hit     = 1'b1;
                hit_way = 2'(w);
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (pending) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit) begin
                    state_d = S_RESPOND;
                end else if (tags[victim].valid && tags[victim].dirty) begin
                    state_d = S_WB_REQ;
                end else begin
                    state_d = S_RF_REQ;
                end
            end
            S_WB_REQ:  state_d = S_WB_WAIT;
            S_WB_WAIT: state_d = mem_wr_done ? S_RF_REQ : S_WB_WAIT;
            S_RF_REQ:  state_d = S_RF_WAIT;
            S_RF_WAIT: state_d = mem_rd_valid ? S_RESPOND : S_RF_WAIT;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= S_IDLE;
            way_q     <= '0;
            wb_open_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_LOOKUP) begin
                way_q <= hit ? hit_way : victim;
            end
            if (mem_wr_req) begin
                wb_open_q <= 1'b1;
            end else if (mem_wr_done) begin
                wb_open_q <= 1'b0;
            end
        end
    end

    // Write hit updates in place, refill fills the chosen way
    always_comb begin
        tag_we          = '0;
        line_we         = '0;
        touch           = 1'b0;
        touch_way       = hit_way;
        base_line       = lines[hit_way];
        tag_wdata.valid = 1'b1;
        tag_wdata.dirty = is_write;
        tag_wdata.tag   = buf_tag;
        if (state_q == S_LOOKUP && hit) begin
            touch = 1'b1;
            if (is_write) begin
                tag_we[hit_way]  = 1'b1;
                line_we[hit_way] = 1'b1;
            end
        end else if (state_q == S_RF_WAIT && mem_rd_valid) begin
            touch          = 1'b1;
            touch_way      = way_q;
            base_line      = mem_rd_line;
            tag_we[way_q]  = 1'b1;
            line_we[way_q] = 1'b1;
        end
        line_wdata = is_write ? merge_word(base_line, buf_offset, buf_wdata, buf_wstrb)
                              : base_line;
    end

    assign way_line  = lines[way_q];
    assign rdata     = way_line[int'(buf_offset[OFFSET_W-1:L1_OFFSET_W]) * L1_LINE_W +: L1_LINE_W];
    assign i_data_ok = (state_q == S_RESPOND) & (buf_src == SRC_ICACHE);
    assign d_data_ok = (state_q == S_RESPOND) & buf_src[1];

    assign mem_wr_req  = (state_q == S_WB_REQ);
    assign mem_rd_req  = (state_q == S_RF_REQ);
    assign mem_rd_addr = {buf_addr[31:OFFSET_W + 2], {(OFFSET_W + 2){1'b0}}};
    assign mem_wr_addr = {tags[way_q].tag, buf_index, {(OFFSET_W + 2){1'b0}}};
    assign mem_wr_line = way_line;

    a_one_data_ok: assert property (@(posedge clk) disable iff (!arst_n)
        !(i_data_ok && d_data_ok));
    a_no_rd_in_wb: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_rd_req && wb_open_q));

endmodule

//--- hw/l2_pkg.sv
package l2_pkg;

    // Cache geometry
    localparam int NUM_WAYS    = 4;
    localparam int INDEX_W     = 2;
    localparam int OFFSET_W    = 4;
    localparam int L1_OFFSET_W = 2;
    localparam int TAG_W       = 32 - INDEX_W - OFFSET_W - 2;

    localparam int NUM_SETS  = 1 << INDEX_W;
    localparam int LINE_W    = 32 << OFFSET_W;
    localparam int L1_LINE_W = 32 << L1_OFFSET_W;

    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [L1_LINE_W-1:0] l1_line_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // Owner of the buffered request
    typedef enum logic [1:0] {
        SRC_NONE   = 2'd0,
        SRC_ICACHE = 2'd1,
        SRC_DREAD  = 2'd2,
        SRC_DWRITE = 2'd3
    } req_src_t;

endpackage

//--- hw/l2_plru.sv
`timescale 1ns/1ps

module l2_plru import l2_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [INDEX_W-1:0]  index,
    input  logic                touch,
    input  logic [1:0]          touch_way,
    input  logic [NUM_WAYS-1:0] valid,
    output logic [1:0]          victim
);
    // Bit 0 picks the pair, bit 1 the lower pair, bit 2 the upper pair
    logic [2:0] tree_q [NUM_SETS];
    logic [2:0] tree;

    assign tree = tree_q[index];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[index][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_q[index][2] <= ~touch_way[0];
            end else begin
                tree_q[index][1] <= ~touch_way[0];
            end
        end
    end

    // Empty ways first, lowest one wins
    always_comb begin
        victim = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                victim = 2'(w);
            end
        end
    end

endmodule

//--- hw/l2_req_buffer.sv
`timescale 1ns/1ps

module l2_req_buffer import l2_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        load,
    input  logic        i_req,
    input  logic [31:0] i_addr,
    input  logic        d_req,
    input  logic        d_wr,
    input  logic [31:0] d_addr,
    input  logic [31:0] d_wdata,
    input  logic [3:0]  d_wstrb,
    output logic        i_addr_ok,
    output logic        d_addr_ok,
    output req_src_t    buf_src,
    output logic [31:0] buf_addr,
    output logic [31:0] buf_wdata,
    output logic [3:0]  buf_wstrb,
    output logic        pending
);
    assign pending = i_req | d_req;

    // Data side wins when both ask
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_src   <= SRC_NONE;
            i_addr_ok <= 1'b0;
            d_addr_ok <= 1'b0;
        end else begin
            i_addr_ok <= load & ~d_req & i_req;
            d_addr_ok <= load & d_req;
            if (load) begin
                if (d_req) begin
                    buf_src <= d_wr ? SRC_DWRITE : SRC_DREAD;
                end else if (i_req) begin
                    buf_src <= SRC_ICACHE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            buf_addr  <= d_req ? d_addr : i_addr;
            buf_wdata <= d_wdata;
            buf_wstrb <= d_wstrb;
        end
    end

    a_i_ok_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        i_addr_ok |-> $past(i_req));
    a_d_ok_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        d_addr_ok |-> $past(d_req));

endmodule

//--- hw/l2_set_ram.sv
`timescale 1ns/1ps

module l2_set_ram import l2_pkg::*; #(
    parameter type entry_t = tag_entry_t
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [INDEX_W-1:0]  rd_index,
    input  logic [INDEX_W-1:0]  wr_index,
    input  logic [NUM_WAYS-1:0] wr_en,
    input  entry_t              wr_data,
    output entry_t              rd_ways [NUM_WAYS]
);
    localparam int DEPTH = NUM_SETS;

    entry_t mem_q [DEPTH][NUM_WAYS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < DEPTH; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    mem_q[s][w] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (wr_en[w]) begin
                    mem_q[wr_index][w] <= wr_data;
                end
            end
        end
    end

    // Whole set visible at once
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            rd_ways[w] = mem_q[rd_index][w];
        end
    end

    a_one_way_written: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(wr_en));

endmodule

//--- list.f
hw/l2_pkg.sv
hw/l2_req_buffer.sv
hw/l2_set_ram.sv
hw/l2_plru.sv
hw/l2_ctrl.sv
hw/l2_cache.sv
bench/tb_clk_gen.sv
bench/l2_cache_tb.sv
